//--- logic/cop_mcu_pkg.sv
//----------------------------
// Shared widths, port 2 strobe
// positions, status pages and
// the bank port union
//----------------------------

package cop_mcu_pkg;

    // Bus widths
    localparam int WORD_W = 16;
    localparam int BYTE_W = 8;
    localparam int SEL_W  = 6;

    // Port 2 bit positions, all active low
    localparam int P2_INT_ACK = 3;
    localparam int P2_RD_HI   = 4;
    localparam int P2_RD_LO   = 5;
    localparam int P2_WR_LO   = 6;
    localparam int P2_WR_HI   = 7;

    // Status dump pages, picked by st_addr[7:6]
    localparam logic [1:0] PAGE_BANK    = 2'd0;
    localparam logic [1:0] PAGE_LATCH   = 2'd1;
    localparam logic [1:0] PAGE_WORD_HI = 2'd2;
    localparam logic [1:0] PAGE_WORD_LO = 2'd3;

    // Port 1 as seen by the ROM banking logic
    typedef struct packed {
        logic       spare;
        logic [1:0] snd;
        logic [1:0] b1;
        logic       b0;
        logic [1:0] mix;
    } bank_port_t;

    // Same byte, whole for the status dump or split into flags
    typedef union packed {
        logic [BYTE_W-1:0] raw;
        bank_port_t        f;
    } bank_port_u;

endpackage

//--- logic/mcu_irq_gen.sv
//----------------------------
// Interrupt line to the MCU,
// set on a select edge and
// cleared by acknowledge
//----------------------------
`timescale 1ns/1ps

module mcu_irq_gen (
    input  logic clk,
    input  logic rst24,
    input  logic sel0,
    input  logic int_ack_n,
    output logic mcu_intn
);

    logic sel0_q;
    logic sel0_rise;

    // Rising edge of the main CPU select
    assign sel0_rise = sel0 & ~sel0_q;

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            sel0_q <= 1'b0;
        end else begin
            sel0_q <= sel0;
        end
    end

    // Acknowledge wins over a new edge in the same cycle
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            mcu_intn <= 1'b1;
        end else begin
            if (!int_ack_n) begin
                mcu_intn <= 1'b1;
            end else if (sel0_rise) begin
                mcu_intn <= 1'b0;
            end
        end
    end

endmodule

//--- logic/mcu_word_latch.sv
//----------------------------
// Byte access between port 0
// and the 16-bit CPU word
//----------------------------
`timescale 1ns/1ps

module mcu_word_latch (
    input  logic                                             clk,
    input  logic                                             rst24,
    input  logic [cop_mcu_pkg::P2_WR_HI:cop_mcu_pkg::P2_RD_HI] strobe_n,
    input  logic [cop_mcu_pkg::WORD_W-1:0]                   mcu_din,
    input  logic [cop_mcu_pkg::BYTE_W-1:0]                   mcu_p0o,
    output logic [cop_mcu_pkg::BYTE_W-1:0]                   mcu_p0i,
    output logic [cop_mcu_pkg::WORD_W-1:0]                   mcu_dout
);

    import cop_mcu_pkg::*;

    logic rd_hi;
    logic rd_lo;
    logic wr_hi;
    logic wr_lo;

    // Port 2 strobes are active low
    assign rd_hi = ~strobe_n[P2_RD_HI];
    assign rd_lo = ~strobe_n[P2_RD_LO];
    assign wr_hi = ~strobe_n[P2_WR_HI];
    assign wr_lo = ~strobe_n[P2_WR_LO];

    // MCU reads, the later assignment makes the low byte win
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            mcu_p0i <= '0;
        end else begin
            if (rd_hi) begin
                mcu_p0i <= mcu_din[WORD_W-1:BYTE_W];
            end
            if (rd_lo) begin
                mcu_p0i <= mcu_din[BYTE_W-1:0];
            end
        end
    end

    // MCU writes, each half on its own strobe
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            mcu_dout <= '0;
        end else begin
            if (wr_hi) begin
                mcu_dout[WORD_W-1:BYTE_W] <= mcu_p0o;
            end
            if (wr_lo) begin
                mcu_dout[BYTE_W-1:0] <= mcu_p0o;
            end
        end
    end

endmodule

//--- logic/mcu_bank_regs.sv
//----------------------------
// ROM bank flags from ports 1
// and 3, port 3 input builder
//----------------------------
`timescale 1ns/1ps

module mcu_bank_regs (
    input  logic                          clk,
    input  logic                          rst24,
    input  logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p1o,
    input  logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p3o,
    input  logic [2:0]                    sel_hi,
    output logic [cop_mcu_pkg::BYTE_W-1:0] bank_raw,
    output logic [1:0]                    snd_flag,
    output logic [1:0]                    b1_flag,
    output logic                          b0_flag,
    output logic [1:0]                    mix_flag,
    output logic [2:0]                    cr_back,
    output logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p3i
);

    import cop_mcu_pkg::*;

    bank_port_u bank_q;
    logic [2:0] cr_back_q;

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            bank_q.raw <= '0;
            cr_back_q  <= '0;
        end else begin
            bank_q.raw <= mcu_p1o;
            // Character bank lives in the low port 3 bits
            cr_back_q  <= mcu_p3o[2:0];
        end
    end

    // Whole byte for the status page
    assign bank_raw = bank_q.raw;

    // Field view for the banking logic
    assign snd_flag = bank_q.f.snd;
    assign b1_flag  = bank_q.f.b1;
    assign b0_flag  = bank_q.f.b0;
    assign mix_flag = bank_q.f.mix;
    assign cr_back  = cr_back_q;

    // What the MCU reads back on port 3
    // upper bits carry the main CPU selects, no register
    assign mcu_p3i = {sel_hi, mcu_p3o[4:0]};

endmodule

//--- logic/status_dump_mux.sv
//----------------------------
// Registered status dump byte
//----------------------------
`timescale 1ns/1ps

module status_dump_mux (
    input  logic                          clk,
    input  logic                          rst24,
    input  logic [1:0]                    page,
    input  logic [cop_mcu_pkg::BYTE_W-1:0] bank_raw,
    input  logic [cop_mcu_pkg::BYTE_W-1:0] snd_latch,
    input  logic [cop_mcu_pkg::WORD_W-1:0] mcu_dout,
    output logic [cop_mcu_pkg::BYTE_W-1:0] st_dout
);

    import cop_mcu_pkg::*;

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            st_dout <= '0;
        end else begin
            case (page)
                PAGE_BANK: begin
                    st_dout <= bank_raw;
                end
                PAGE_LATCH: begin
                    st_dout <= snd_latch;
                end
                PAGE_WORD_HI: begin
                    st_dout <= mcu_dout[WORD_W-1:BYTE_W];
                end
                PAGE_WORD_LO: begin
                    st_dout <= mcu_dout[BYTE_W-1:0];
                end
                default: begin
                    st_dout <= '0;
                end
            endcase
        end
    end

endmodule

//--- logic/mcu_port_bridge.sv
//----------------------------
// MCU to main CPU bridge, top
// level with interrupt, word
// latch, banks and status
//----------------------------
`timescale 1ns/1ps

module mcu_port_bridge (
    input  logic                          clk,
    input  logic                          rst24,
    input  logic [cop_mcu_pkg::SEL_W-1:0]  mcu_sel,
    input  logic [cop_mcu_pkg::WORD_W-1:0] mcu_din,
    input  logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p0o,
    input  logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p1o,
    input  logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p2o,
    input  logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p3o,
    input  logic [cop_mcu_pkg::BYTE_W-1:0] snd_latch,
    input  logic [cop_mcu_pkg::BYTE_W-1:0] st_addr,
    output logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p0i,
    output logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p3i,
    output logic                          mcu_intn,
    output logic [cop_mcu_pkg::WORD_W-1:0] mcu_dout,
    output logic [1:0]                    snd_flag,
    output logic [1:0]                    b1_flag,
    output logic                          b0_flag,
    output logic [1:0]                    mix_flag,
    output logic [2:0]                    cr_back,
    output logic [cop_mcu_pkg::BYTE_W-1:0] st_dout
);

    import cop_mcu_pkg::*;

    logic [BYTE_W-1:0] bank_raw;

    mcu_irq_gen mcu_irq_gen_inst (
        .clk       (clk),
        .rst24     (rst24),
        .sel0      (mcu_sel[0]),
        .int_ack_n (mcu_p2o[P2_INT_ACK]),
        .mcu_intn  (mcu_intn)
    );

    // Read and write strobes sit on port 2 bits 7 to 4
    mcu_word_latch mcu_word_latch_inst (
        .clk      (clk),
        .rst24    (rst24),
        .strobe_n (mcu_p2o[P2_WR_HI:P2_RD_HI]),
        .mcu_din  (mcu_din),
        .mcu_p0o  (mcu_p0o),
        .mcu_p0i  (mcu_p0i),
        .mcu_dout (mcu_dout)
    );

    mcu_bank_regs mcu_bank_regs_inst (
        .clk      (clk),
        .rst24    (rst24),
        .mcu_p1o  (mcu_p1o),
        .mcu_p3o  (mcu_p3o),
        .sel_hi   (mcu_sel[5:3]),
        .bank_raw (bank_raw),
        .snd_flag (snd_flag),
        .b1_flag  (b1_flag),
        .b0_flag  (b0_flag),
        .mix_flag (mix_flag),
        .cr_back  (cr_back),
        .mcu_p3i  (mcu_p3i)
    );

    // Page comes from the top two status address bits
    status_dump_mux status_dump_mux_inst (
        .clk       (clk),
        .rst24     (rst24),
        .page      (st_addr[7:6]),
        .bank_raw  (bank_raw),
        .snd_latch (snd_latch),
        .mcu_dout  (mcu_dout),
        .st_dout   (st_dout)
    );

endmodule

//--- tb/mcu_port_bridge_props.sv
//----------------------------
// Concurrent timing checks on
// the MCU port bridge
//----------------------------
`timescale 1ns/1ps

module mcu_port_bridge_props (
    input logic                          clk,
    input logic                          rst24,
    input logic [cop_mcu_pkg::SEL_W-1:0]  mcu_sel,
    input logic [cop_mcu_pkg::WORD_W-1:0] mcu_din,
    input logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p2o,
    input logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p3o,
    input logic                          mcu_intn,
    input logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p0i,
    input logic [cop_mcu_pkg::BYTE_W-1:0] mcu_p3i,
    input logic [2:0]                    cr_back
);

    import cop_mcu_pkg::*;

    // Number of failed properties, watched by the testbench
    int err_cnt = 0;

    // Select edge with acknowledge idle pulls the interrupt low
    irq_set_on_edge: assert property (
        @(posedge clk) disable iff (rst24)
        (mcu_sel[0] && !$past(mcu_sel[0]) && mcu_p2o[P2_INT_ACK]) |=> !mcu_intn
    ) else begin
        err_cnt = err_cnt + 1;
        $error("interrupt not raised one cycle after a select edge");
    end

    irq_held_low: assert property (
        @(posedge clk) disable iff (rst24)
        (!mcu_intn && mcu_p2o[P2_INT_ACK]) |=> !mcu_intn
    ) else begin
        err_cnt = err_cnt + 1;
        $error("interrupt released without an acknowledge");
    end

    irq_release_on_ack: assert property (
        @(posedge clk) disable iff (rst24)
        !mcu_p2o[P2_INT_ACK] |=> mcu_intn
    ) else begin
        err_cnt = err_cnt + 1;
        $error("interrupt still low one cycle after acknowledge");
    end

    // Low byte read has priority over the high byte read
    read_low_byte: assert property (
        @(posedge clk) disable iff (rst24)
        !mcu_p2o[P2_RD_LO] |=> (mcu_p0i == $past(mcu_din[BYTE_W-1:0]))
    ) else begin
        err_cnt = err_cnt + 1;
        $error("port 0 input does not hold the low byte after a low read");
    end

    read_high_byte: assert property (
        @(posedge clk) disable iff (rst24)
        (!mcu_p2o[P2_RD_HI] && mcu_p2o[P2_RD_LO])
            |=> (mcu_p0i == $past(mcu_din[WORD_W-1:BYTE_W]))
    ) else begin
        err_cnt = err_cnt + 1;
        $error("port 0 input does not hold the high byte after a high read");
    end

    cr_back_follows: assert property (
        @(posedge clk) disable iff (rst24)
        1'b1 |=> (cr_back == $past(mcu_p3o[2:0]))
    ) else begin
        err_cnt = err_cnt + 1;
        $error("character bank does not follow port 3 after one cycle");
    end

    // Port 3 input has no register
    p3_input_comb: assert property (
        @(posedge clk) disable iff (rst24)
        mcu_p3i == {mcu_sel[5:3], mcu_p3o[4:0]}
    ) else begin
        err_cnt = err_cnt + 1;
        $error("port 3 input is not built from the selects and port 3");
    end

endmodule

//--- tb/tb_mcu_port_bridge.sv
//----------------------------
// Testbench for the MCU port
// bridge with watchdog
//----------------------------
`timescale 1ns/1ps

module tb_mcu_port_bridge;

    import cop_mcu_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 4;
    localparam int N_RAND      = 16;
    // Reset, interrupt phase and the random phases with slack
    localparam int TEST_CYCLES = RST_CYCLES + 16 + 10 * N_RAND;
    localparam int TIMEOUT_NS  = (TEST_CYCLES + 50) * CLK_PERIOD;

    logic              clk;
    logic              rst24;
    logic [SEL_W-1:0]  mcu_sel;
    logic [WORD_W-1:0] mcu_din;
    logic [BYTE_W-1:0] mcu_p0o;
    logic [BYTE_W-1:0] mcu_p1o;
    logic [BYTE_W-1:0] mcu_p2o;
    logic [BYTE_W-1:0] mcu_p3o;
    logic [BYTE_W-1:0] snd_latch;
    logic [BYTE_W-1:0] st_addr;
    logic [BYTE_W-1:0] mcu_p0i;
    logic [BYTE_W-1:0] mcu_p3i;
    logic              mcu_intn;
    logic [WORD_W-1:0] mcu_dout;
    logic [1:0]        snd_flag;
    logic [1:0]        b1_flag;
    logic              b0_flag;
    logic [1:0]        mix_flag;
    logic [2:0]        cr_back;
    logic [BYTE_W-1:0] st_dout;

    integer            seed;
    logic [31:0]       rnd;
    logic [WORD_W-1:0] exp_dout;
    logic [BYTE_W-1:0] exp_st;
    logic [1:0]        page;

    mcu_port_bridge mcu_port_bridge_inst (
        .clk       (clk),
        .rst24     (rst24),
        .mcu_sel   (mcu_sel),
        .mcu_din   (mcu_din),
        .mcu_p0o   (mcu_p0o),
        .mcu_p1o   (mcu_p1o),
        .mcu_p2o   (mcu_p2o),
        .mcu_p3o   (mcu_p3o),
        .snd_latch (snd_latch),
        .st_addr   (st_addr),
        .mcu_p0i   (mcu_p0i),
        .mcu_p3i   (mcu_p3i),
        .mcu_intn  (mcu_intn),
        .mcu_dout  (mcu_dout),
        .snd_flag  (snd_flag),
        .b1_flag   (b1_flag),
        .b0_flag   (b0_flag),
        .mix_flag  (mix_flag),
        .cr_back   (cr_back),
        .st_dout   (st_dout)
    );

    bind mcu_port_bridge mcu_port_bridge_props props_inst (
        .clk      (clk),
        .rst24    (rst24),
        .mcu_sel  (mcu_sel),
        .mcu_din  (mcu_din),
        .mcu_p2o  (mcu_p2o),
        .mcu_p3o  (mcu_p3o),
        .mcu_intn (mcu_intn),
        .mcu_p0i  (mcu_p0i),
        .mcu_p3i  (mcu_p3i),
        .cr_back  (cr_back)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got == exp)
        else fail_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
    endtask

    // Bound properties count their failures
    always @(negedge clk) begin
        if (mcu_port_bridge_inst.props_inst.err_cnt != 0) begin
            fail_run("A concurrent timing property of the bridge failed");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        fail_run("Watchdog expired before the tests finished");
    end

    initial begin
        seed      = 32'hea2d;
        rst24     = 1'b1;
        mcu_sel   = '0;
        mcu_din   = '0;
        mcu_p0o   = '0;
        mcu_p1o   = '0;
        // Strobes and acknowledge idle high
        mcu_p2o   = 8'hff;
        mcu_p3o   = '0;
        snd_latch = '0;
        st_addr   = '0;
        exp_dout  = '0;

        repeat (RST_CYCLES) begin
            @(negedge clk);
            check_value("mcu_intn", 16'(mcu_intn), 16'h1);
            check_value("mcu_p0i", 16'(mcu_p0i), 16'h0);
            check_value("mcu_dout", mcu_dout, 16'h0);
            check_value("snd_flag", 16'(snd_flag), 16'h0);
            check_value("b1_flag", 16'(b1_flag), 16'h0);
            check_value("b0_flag", 16'(b0_flag), 16'h0);
            check_value("mix_flag", 16'(mix_flag), 16'h0);
            check_value("cr_back", 16'(cr_back), 16'h0);
            check_value("st_dout", 16'(st_dout), 16'h0);
        end
        rst24 = 1'b0;

        // Interrupt raised by a select edge
        @(negedge clk);
        mcu_sel[0] = 1'b1;
        @(negedge clk);
        check_value("mcu_intn", 16'(mcu_intn), 16'h0);
        mcu_sel[0] = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("mcu_intn", 16'(mcu_intn), 16'h0);
        end
        mcu_p2o[P2_INT_ACK] = 1'b0;
        @(negedge clk);
        check_value("mcu_intn", 16'(mcu_intn), 16'h1);
        // Edge during acknowledge leaves the line high
        mcu_sel[0] = 1'b1;
        @(negedge clk);
        check_value("mcu_intn", 16'(mcu_intn), 16'h1);
        mcu_p2o[P2_INT_ACK] = 1'b1;
        @(negedge clk);
        check_value("mcu_intn", 16'(mcu_intn), 16'h1);
        mcu_sel[0] = 1'b0;

        // Reads, high then low then both strobes
        for (int i = 0; i < N_RAND; i++) begin
            rnd = $random(seed);
            mcu_din = rnd[15:0];
            mcu_p2o[P2_RD_HI] = 1'b0;
            @(negedge clk);
            check_value("mcu_p0i", 16'(mcu_p0i), 16'(rnd[15:8]));
            rnd = $random(seed);
            mcu_din = rnd[15:0];
            mcu_p2o[P2_RD_HI] = 1'b1;
            mcu_p2o[P2_RD_LO] = 1'b0;
            @(negedge clk);
            check_value("mcu_p0i", 16'(mcu_p0i), 16'(rnd[7:0]));
            rnd = $random(seed);
            mcu_din = rnd[15:0];
            mcu_p2o[P2_RD_HI] = 1'b0;
            @(negedge clk);
            check_value("mcu_p0i", 16'(mcu_p0i), 16'(rnd[7:0]));
            mcu_p2o[P2_RD_HI] = 1'b1;
            mcu_p2o[P2_RD_LO] = 1'b1;
        end

        // Writes, one half per strobe
        for (int i = 0; i < N_RAND; i++) begin
            rnd = $random(seed);
            mcu_p0o = rnd[7:0];
            mcu_p2o[P2_WR_HI] = 1'b0;
            exp_dout[15:8] = rnd[7:0];
            @(negedge clk);
            check_value("mcu_dout", mcu_dout, exp_dout);
            mcu_p0o = rnd[15:8];
            mcu_p2o[P2_WR_HI] = 1'b1;
            mcu_p2o[P2_WR_LO] = 1'b0;
            exp_dout[7:0] = rnd[15:8];
            @(negedge clk);
            check_value("mcu_dout", mcu_dout, exp_dout);
            mcu_p2o[P2_WR_LO] = 1'b1;
        end

        // Bank flags from port 1 fields and port 3
        for (int i = 0; i < N_RAND; i++) begin
            rnd = $random(seed);
            mcu_p1o = rnd[7:0];
            mcu_p3o = rnd[15:8];
            mcu_sel = rnd[21:16];
            #1;
            check_value("mcu_p3i", 16'(mcu_p3i), 16'({rnd[21:19], rnd[12:8]}));
            @(negedge clk);
            check_value("snd_flag", 16'(snd_flag), 16'(rnd[6:5]));
            check_value("b1_flag", 16'(b1_flag), 16'(rnd[4:3]));
            check_value("b0_flag", 16'(b0_flag), 16'(rnd[2]));
            check_value("mix_flag", 16'(mix_flag), 16'(rnd[1:0]));
            check_value("cr_back", 16'(cr_back), 16'(rnd[10:8]));
        end

        // Status pages in turn
        for (int i = 0; i < N_RAND; i++) begin
            rnd = $random(seed);
            page = i[1:0];
            snd_latch = rnd[7:0];
            st_addr = {page, rnd[13:8]};
            case (page)
                PAGE_BANK:    exp_st = mcu_p1o;
                PAGE_LATCH:   exp_st = rnd[7:0];
                PAGE_WORD_HI: exp_st = exp_dout[15:8];
                default:      exp_st = exp_dout[7:0];
            endcase
            @(negedge clk);
            check_value("st_dout", 16'(st_dout), 16'(exp_st));
        end

        @(negedge clk);
        if (mcu_port_bridge_inst.props_inst.err_cnt != 0) begin
            fail_run("A concurrent timing property of the bridge failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- all.f
logic/cop_mcu_pkg.sv
logic/mcu_irq_gen.sv
logic/mcu_word_latch.sv
logic/mcu_bank_regs.sv
logic/status_dump_mux.sv
logic/mcu_port_bridge.sv
tb/mcu_port_bridge_props.sv
tb/tb_mcu_port_bridge.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mcu_port_bridge
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIMFLAGS  := +verilator+error+limit+100

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(SIMFLAGS) 2>&1 | tee $(LOG)
	grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
